// File: design/rv_decode_pkg.sv
// RV64I decoder types and constants, imported by each design file and by the testbench
package rv_decode_pkg;

    localparam int XLEN = 64;

    // funct7 values that the base set uses
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_AUIPC     = 7'b0010111,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_LUI       = 7'b0110111,
        OPC_OP_32     = 7'b0111011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JALR      = 7'b1100111,
        OPC_JAL       = 7'b1101111,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    // Instruction type codes, numbering kept from the existing decoder
    typedef enum logic [7:0] {
        // Register-register
        ADD   = 8'd0,  SUB    = 8'd1,  XOR    = 8'd2,  OR     = 8'd3,
        AND   = 8'd4,  SLL    = 8'd5,  SRL    = 8'd6,  SRA    = 8'd7,
        SLT   = 8'd8,  SLTU   = 8'd9,
        // Register-immediate
        ADDI  = 8'd18, XORI   = 8'd19, ORI    = 8'd20, ANDI   = 8'd21,
        SLLI  = 8'd22, SRLI   = 8'd23, SRAI   = 8'd24, SLTI   = 8'd25,
        SLTIU = 8'd26,
        // Word forms
        ADDIW = 8'd29, SLLIW  = 8'd30, SRLIW  = 8'd31, SRAIW  = 8'd32,
        ADDW  = 8'd33, SUBW   = 8'd34, SLLW   = 8'd35, SRLW   = 8'd36,
        SRAW  = 8'd37,
        // Stores and branches
        SB    = 8'd43, SH     = 8'd44, SW     = 8'd45, SD     = 8'd46,
        BEQ   = 8'd47, BNE    = 8'd48, BLT    = 8'd49, BGE    = 8'd50,
        BLTU  = 8'd51, BGEU   = 8'd52,
        // Jumps, upper immediates, system
        JAL   = 8'd53, JALR   = 8'd54, LUI    = 8'd55, AUIPC  = 8'd56,
        ECALL = 8'd57, EBREAK = 8'd58,
        // Loads
        LB    = 8'd59, LH     = 8'd60, LW     = 8'd61, LBU    = 8'd62,
        LHU   = 8'd63, LWU    = 8'd64, LD     = 8'd65,
        UNKNOWN = 8'd255
    } instr_type_e;

    // Encoding format, picks which fields and immediate layout apply
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } format_e;

    // Raw fields, zero where the format does not define them
    typedef struct packed {
        logic [6:0] opcode;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } reg_fields_t;

    // Registered decode result
    typedef struct packed {
        logic [6:0]      opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;          // Sign-extended
        logic [XLEN-1:0] shamt;        // Low 6 bits at most
        instr_type_e     instr_type;
        logic            memory_access;
        logic            illegal;
    } decode_out_t;

endpackage

// File: design/field_extract.sv
// Splits an instruction word into its register and function fields and picks the format

`timescale 1ns/100ps

module field_extract import rv_decode_pkg::*; (
    input  logic [31:0] instruction,
    output reg_fields_t fields,
    output format_e     format
);

    logic [6:0] opcode;

    assign opcode = instruction[6:0];

    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_32:        format = FMT_R;
            OPC_OP_IMM, OPC_OP_IMM_32,
            OPC_LOAD, OPC_JALR,
            OPC_SYSTEM:               format = FMT_I;
            OPC_STORE:                format = FMT_S;
            OPC_BRANCH:               format = FMT_B;
            OPC_LUI, OPC_AUIPC:       format = FMT_U;
            OPC_JAL:                  format = FMT_J;
            default:                  format = FMT_NONE;
        endcase
    end

    // Opcode always passes through so an unknown word is still visible downstream
    always_comb begin
        fields        = '0;
        fields.opcode = opcode;

        if (format inside {FMT_R, FMT_I, FMT_U, FMT_J}) begin
            fields.rd = instruction[11:7];
        end
        if (format inside {FMT_R, FMT_I, FMT_S, FMT_B}) begin
            fields.rs1    = instruction[19:15];
            fields.funct3 = instruction[14:12];
        end
        if (format inside {FMT_R, FMT_S, FMT_B}) begin
            fields.rs2 = instruction[24:20];
        end
        if (format == FMT_R) begin
            fields.funct7 = instruction[31:25];
        end
    end

endmodule

// File: design/imm_gen.sv
// Builds the sign-extended immediate and the shift amount for the selected format

`timescale 1ns/100ps

module imm_gen import rv_decode_pkg::*; (
    input  logic [31:0]     instruction,
    input  reg_fields_t     fields,
    input  format_e         format,
    output logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] shamt
);

    logic sign;
    logic is_shift;

    assign sign     = instruction[31];
    assign is_shift = (fields.funct3 == 3'b001) || (fields.funct3 == 3'b101);

    always_comb begin
        case (format)
            FMT_I: imm = {{(XLEN-12){sign}}, instruction[31:20]};
            FMT_S: imm = {{(XLEN-12){sign}}, instruction[31:25], instruction[11:7]};
            FMT_B: begin
                imm = {{(XLEN-13){sign}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            FMT_U: imm = {{(XLEN-32){sign}}, instruction[31:12], 12'b0};
            FMT_J: begin
                imm = {{(XLEN-21){sign}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            default: imm = '0;  // R and NONE carry no immediate
        endcase
    end

    // RV64 shifts take 6 bits, word shifts 5
    always_comb begin
        shamt = '0;
        if (is_shift) begin
            case (fields.opcode)
                OPC_OP_IMM:    shamt = {{(XLEN-6){1'b0}}, instruction[25:20]};
                OPC_OP_IMM_32: shamt = {{(XLEN-5){1'b0}}, instruction[24:20]};
                default:       shamt = '0;
            endcase
        end
    end

    always_comb begin
        assert final (shamt <= 63)
            else $error("shamt out of range: %0d", shamt);
    end

endmodule

// File: design/instr_classify.sv
// Maps opcode and function fields to a type code and the memory, illegal and bubble flags

`timescale 1ns/100ps

module instr_classify import rv_decode_pkg::*; (
    input  reg_fields_t fields,
    input  logic [31:0] instruction,
    output instr_type_e instr_type,
    output logic        memory_access,
    output logic        illegal,
    output logic        bubble
);

    logic [5:0]  shift_hi6;   // Upper bits of a 6-bit shift immediate
    logic [6:0]  shift_hi7;   // Upper bits of a word shift immediate
    logic [11:0] sys_imm;

    assign shift_hi6 = instruction[31:26];
    assign shift_hi7 = instruction[31:25];
    assign sys_imm   = instruction[31:20];

    always_comb begin
        instr_type = UNKNOWN;
        case (fields.opcode)
            OPC_OP: begin
                // M extension (funct7 = 1) falls through to UNKNOWN
                if (fields.funct7 == FUNCT7_BASE) begin
                    case (fields.funct3)
                        3'b000:  instr_type = ADD;
                        3'b001:  instr_type = SLL;
                        3'b010:  instr_type = SLT;
                        3'b011:  instr_type = SLTU;
                        3'b100:  instr_type = XOR;
                        3'b101:  instr_type = SRL;
                        3'b110:  instr_type = OR;
                        default: instr_type = AND;
                    endcase
                end else if (fields.funct7 == FUNCT7_ALT) begin
                    if (fields.funct3 == 3'b000) instr_type = SUB;
                    else if (fields.funct3 == 3'b101) instr_type = SRA;
                end
            end
            OPC_OP_IMM: begin
                case (fields.funct3)
                    3'b000: instr_type = ADDI;
                    3'b010: instr_type = SLTI;
                    3'b011: instr_type = SLTIU;
                    3'b100: instr_type = XORI;
                    3'b110: instr_type = ORI;
                    3'b111: instr_type = ANDI;
                    3'b001: if (shift_hi6 == 6'b000000) instr_type = SLLI;
                    default: begin
                        if (shift_hi6 == 6'b000000) instr_type = SRLI;
                        else if (shift_hi6 == 6'b010000) instr_type = SRAI;
                    end
                endcase
            end
            OPC_OP_IMM_32: begin
                case (fields.funct3)
                    3'b000: instr_type = ADDIW;
                    3'b001: if (shift_hi7 == FUNCT7_BASE) instr_type = SLLIW;
                    3'b101: begin
                        if (shift_hi7 == FUNCT7_BASE) instr_type = SRLIW;
                        else if (shift_hi7 == FUNCT7_ALT) instr_type = SRAIW;
                    end
                    default: ;
                endcase
            end
            OPC_OP_32: begin
                if (fields.funct7 == FUNCT7_BASE) begin
                    case (fields.funct3)
                        3'b000:  instr_type = ADDW;
                        3'b001:  instr_type = SLLW;
                        3'b101:  instr_type = SRLW;
                        default: ;
                    endcase
                end else if (fields.funct7 == FUNCT7_ALT) begin
                    if (fields.funct3 == 3'b000) instr_type = SUBW;
                    else if (fields.funct3 == 3'b101) instr_type = SRAW;
                end
            end
            OPC_LOAD: begin
                case (fields.funct3)
                    3'b000:  instr_type = LB;
                    3'b001:  instr_type = LH;
                    3'b010:  instr_type = LW;
                    3'b011:  instr_type = LD;
                    3'b100:  instr_type = LBU;
                    3'b101:  instr_type = LHU;
                    3'b110:  instr_type = LWU;
                    default: ;
                endcase
            end
            OPC_STORE: begin
                case (fields.funct3)
                    3'b000:  instr_type = SB;
                    3'b001:  instr_type = SH;
                    3'b010:  instr_type = SW;
                    3'b011:  instr_type = SD;
                    default: ;
                endcase
            end
            OPC_BRANCH: begin
                case (fields.funct3)
                    3'b000:  instr_type = BEQ;
                    3'b001:  instr_type = BNE;
                    3'b100:  instr_type = BLT;
                    3'b101:  instr_type = BGE;
                    3'b110:  instr_type = BLTU;
                    3'b111:  instr_type = BGEU;
                    default: ;
                endcase
            end
            OPC_JAL:   instr_type = JAL;
            OPC_JALR:  instr_type = JALR;
            OPC_LUI:   instr_type = LUI;
            OPC_AUIPC: instr_type = AUIPC;
            OPC_SYSTEM: begin
                if (fields.funct3 == 3'b000) begin
                    if (sys_imm == 12'h000) instr_type = ECALL;
                    else if (sys_imm == 12'h001) instr_type = EBREAK;
                end
            end
            default: ;
        endcase
    end

    assign bubble        = (instruction == 32'b0);
    assign memory_access = (fields.opcode == OPC_LOAD) || (fields.opcode == OPC_STORE);
    assign illegal       = (instr_type == UNKNOWN) && !bubble;  // A zero word is a bubble

    always_comb begin
        assert final (!(illegal && bubble))
            else $error("illegal and bubble both set for %h", instruction);
    end

endmodule

// File: design/decode_stage.sv
// Output register of the decoder, captures the result and pulses decode_complete

`timescale 1ns/100ps

module decode_stage import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            decode_enable,
    input  reg_fields_t     fields,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] shamt,
    input  instr_type_e     instr_type,
    input  logic            memory_access,
    input  logic            illegal,
    input  logic            bubble,
    output decode_out_t     decoded,
    output logic            decode_complete
);

    decode_out_t result;
    logic        capture;

    assign capture = decode_enable && !bubble;  // Zero words never complete

    always_comb begin
        result.opcode        = fields.opcode;
        result.rd            = fields.rd;
        result.rs1           = fields.rs1;
        result.rs2           = fields.rs2;
        result.imm           = imm;
        result.shamt         = shamt;
        result.instr_type    = instr_type;
        result.memory_access = memory_access;
        result.illegal       = illegal;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded         <= '0;
            decode_complete <= 1'b0;
        end else begin
            decode_complete <= capture;
            if (capture) begin
                decoded <= result;  // Held until the next completed decode
            end
        end
    end

    assert property (@(posedge clk) reset |=> !decode_complete)
        else $error("decode_complete high in the cycle after reset");

    assert property (@(posedge clk) disable iff (reset) decode_complete |-> $past(decode_enable))
        else $error("decode_complete without a strobe one cycle earlier");

endmodule

// File: design/rv_decoder_top.sv
// RV64I instruction decoder top, one strobe in and a registered result one clock later

`timescale 1ns/100ps

module rv_decoder_top import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        decode_enable,
    input  logic [31:0] instruction,
    output decode_out_t decoded,
    output logic        decode_complete
);

    reg_fields_t     fields;
    format_e         format;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] shamt;
    instr_type_e     instr_type;
    logic            memory_access;
    logic            illegal;
    logic            bubble;

    field_extract u_field_extract (
        .instruction (instruction),
        .fields      (fields),
        .format      (format)
    );

    imm_gen u_imm_gen (
        .instruction (instruction),
        .fields      (fields),
        .format      (format),
        .imm         (imm),
        .shamt       (shamt)
    );

    instr_classify u_instr_classify (
        .fields        (fields),
        .instruction   (instruction),
        .instr_type    (instr_type),
        .memory_access (memory_access),
        .illegal       (illegal),
        .bubble        (bubble)
    );

    decode_stage u_decode_stage (
        .clk             (clk),
        .reset           (reset),
        .decode_enable   (decode_enable),
        .fields          (fields),
        .imm             (imm),
        .shamt           (shamt),
        .instr_type      (instr_type),
        .memory_access   (memory_access),
        .illegal         (illegal),
        .bubble          (bubble),
        .decoded         (decoded),
        .decode_complete (decode_complete)
    );

endmodule

// File: dv/decode_ref.svh
// Reference RV64I decode built from the ISA encoding rules, included inside the testbench module
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// Expected registered result for one word, plus whether the word is a bubble
function automatic decode_out_t ref_decode(input logic [31:0] w, output logic is_bubble);
    decode_out_t d;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [2:0]  has;  // rd, rs1, rs2 present
    instr_type_e t;
    d = '0;
    f3 = w[14:12];
    f7 = w[31:25];
    has = 3'b000;
    t = UNKNOWN;
    d.opcode = w[6:0];
    is_bubble = (w == 32'b0);
    case (w[6:0])
        OPC_OP, OPC_OP_32: begin
            has = 3'b111;
            case ({w[3], f7, f3})  // Bit 3 marks the word forms
                {1'b0, 7'h00, 3'd0}: t = ADD;
                {1'b0, 7'h20, 3'd0}: t = SUB;
                {1'b0, 7'h00, 3'd1}: t = SLL;
                {1'b0, 7'h00, 3'd2}: t = SLT;
                {1'b0, 7'h00, 3'd3}: t = SLTU;
                {1'b0, 7'h00, 3'd4}: t = XOR;
                {1'b0, 7'h00, 3'd5}: t = SRL;
                {1'b0, 7'h20, 3'd5}: t = SRA;
                {1'b0, 7'h00, 3'd6}: t = OR;
                {1'b0, 7'h00, 3'd7}: t = AND;
                {1'b1, 7'h00, 3'd0}: t = ADDW;
                {1'b1, 7'h20, 3'd0}: t = SUBW;
                {1'b1, 7'h00, 3'd1}: t = SLLW;
                {1'b1, 7'h00, 3'd5}: t = SRLW;
                {1'b1, 7'h20, 3'd5}: t = SRAW;
                default: t = UNKNOWN;  // M extension included
            endcase
        end
        OPC_OP_IMM: begin
            has = 3'b110;
            d.imm = $signed(w[31:20]);
            if (f3 == 3'd1 || f3 == 3'd5) d.shamt = w[25:20];
            case (f3)
                3'd0: t = ADDI;
                3'd1: t = (w[31:26] == 6'h00) ? SLLI : UNKNOWN;
                3'd2: t = SLTI;
                3'd3: t = SLTIU;
                3'd4: t = XORI;
                3'd5: t = (w[31:26] == 6'h00) ? SRLI : (w[31:26] == 6'h10) ? SRAI : UNKNOWN;
                3'd6: t = ORI;
                default: t = ANDI;
            endcase
        end
        OPC_OP_IMM_32: begin
            has = 3'b110;
            d.imm = $signed(w[31:20]);
            if (f3 == 3'd1 || f3 == 3'd5) d.shamt = w[24:20];
            if (f3 == 3'd0) t = ADDIW;
            if (f3 == 3'd1 && f7 == 7'h00) t = SLLIW;
            if (f3 == 3'd5 && f7 == 7'h00) t = SRLIW;
            if (f3 == 3'd5 && f7 == 7'h20) t = SRAIW;
        end
        OPC_LOAD: begin
            has = 3'b110;
            d.imm = $signed(w[31:20]);
            if (f3 != 3'd7) t = instr_type_e'(f3 == 3'd3 ? 65 : f3 > 3'd3 ? 58 + f3 : 59 + f3);
        end
        OPC_STORE: begin
            has = 3'b011;
            d.imm = $signed({w[31:25], w[11:7]});
            if (f3 < 3'd4) t = instr_type_e'(43 + f3);
        end
        OPC_BRANCH: begin
            has = 3'b011;
            d.imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            if (f3 < 3'd2) t = instr_type_e'(47 + f3);
            else if (f3 > 3'd3) t = instr_type_e'(45 + f3);
        end
        OPC_JAL: begin
            has = 3'b100;
            d.imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            t = JAL;
        end
        OPC_JALR, OPC_SYSTEM: begin
            has = 3'b110;
            d.imm = $signed(w[31:20]);
            if (w[6:0] == OPC_JALR) t = JALR;
            else if (f3 == 3'd0 && w[31:20] == 12'd0) t = ECALL;
            else if (f3 == 3'd0 && w[31:20] == 12'd1) t = EBREAK;
        end
        OPC_LUI, OPC_AUIPC: begin
            has = 3'b100;
            d.imm = $signed({w[31:12], 12'h000});
            t = (w[6:0] == OPC_LUI) ? LUI : AUIPC;
        end
        default: ;  // Unknown opcode keeps only the opcode
    endcase
    d.rd = has[2] ? w[11:7] : 5'd0;
    d.rs1 = has[1] ? w[19:15] : 5'd0;
    d.rs2 = has[0] ? w[24:20] : 5'd0;
    d.instr_type = t;
    d.memory_access = (w[6:0] == OPC_LOAD) || (w[6:0] == OPC_STORE);
    d.illegal = (t == UNKNOWN) && !is_bubble;
    return d;
endfunction

`endif

// File: dv/rv_decoder_tb.sv
// Testbench for the RV64I decoder, runs directed, shift, illegal and random stream tests
`timescale 1ns/100ps

module rv_decoder_tb import rv_decode_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int STREAM_LEN   = 400;
    localparam int TOTAL_CYCLES = 2 + 52 + 126 + 30 + STREAM_LEN + 3;  // Driven by all phases
    localparam logic [83:0] OPCODES = {OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_OP_IMM_32,
                                       OPC_STORE, OPC_OP, OPC_LUI, OPC_OP_32,
                                       OPC_BRANCH, OPC_JALR, OPC_JAL, OPC_SYSTEM};

    logic        clk = 1'b0;
    logic        reset;
    logic        decode_enable;
    logic [31:0] instruction;
    decode_out_t decoded;
    logic        decode_complete;

    decode_out_t want_q[$];  // One entry per non-bubble strobe
    string       name_q[$];
    decode_out_t last_decoded = '0;
    logic        strobe_seen = 1'b0;
    int unsigned seed_val;

    `include "decode_ref.svh"

    rv_decoder_top DUT (
        .clk             (clk),
        .reset           (reset),
        .decode_enable   (decode_enable),
        .instruction     (instruction),
        .decoded         (decoded),
        .decode_complete (decode_complete)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string what, input logic [191:0] expected,
                         input logic [191:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", what, expected, actual);
            abort_run();
        end
    endtask

    // Drives one cycle and queues the expected result of a non-bubble strobe
    task automatic drive(input logic en, input logic [31:0] w, input string name);
        decode_out_t d;
        logic        bub;
        d = ref_decode(w, bub);
        if (en && !bub) begin
            want_q.push_back(d);
            name_q.push_back(name);
        end
        decode_enable <= en;
        instruction <= w;
        @(posedge clk);
    endtask

    function automatic logic known_opcode(input logic [6:0] op);
        for (int k = 0; k < 12; k++) begin
            if (OPCODES[7*k +: 7] == op)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // Biased toward known opcodes and the funct7 and SYSTEM values that decode
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        int          k;
        w = $urandom;
        k = $urandom_range(0, 11);
        w[6:0] = OPCODES[7*k +: 7];
        case ($urandom_range(0, 3))
            0: w[31:25] = FUNCT7_BASE;
            1: w[31:25] = FUNCT7_ALT;
            2: w[31:20] = {11'b0, w[20]};
            default: ;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] find_word(input instr_type_e want);
        logic [31:0] w;
        logic        bub;
        decode_out_t d;
        for (int i = 0; i < 100000; i++) begin
            w = random_word();
            d = ref_decode(w, bub);
            if (d.instr_type == want)
                return w;
        end
        return 32'b0;
    endfunction

    task automatic shift_case(input string name, input logic [6:0] opc, input logic [2:0] f3,
                              input logic [6:0] f7, input logic [5:0] amount,
                              input instr_type_e want);
        logic [31:0] w;
        logic [5:0]  want_sh;
        decode_out_t d;
        logic        bub;
        w = $urandom;
        w[6:0] = opc;
        w[14:12] = f3;
        if (opc == OPC_OP_IMM) w[31:20] = {f7[6:1], amount};
        else w[31:20] = {f7, amount[4:0]};
        want_sh = (opc == OPC_OP_IMM) ? amount : {1'b0, amount[4:0]};
        d = ref_decode(w, bub);
        check({name, " ref type"}, want, d.instr_type);
        check({name, " ref shamt"}, {58'b0, want_sh}, d.shamt);
        drive(1'b1, w, name);
    endtask

    task automatic illegal_case(input string name, input logic [31:0] w);
        decode_out_t d;
        logic        bub;
        d = ref_decode(w, bub);
        check({name, " ref type"}, UNKNOWN, d.instr_type);
        check({name, " ref illegal"}, 1'b1, d.illegal);
        drive(1'b1, w, name);
    endtask

    initial begin
        instr_type_e t;
        logic [31:0] w;
        decode_out_t d;
        logic        bub;
        seed_val = $urandom(32'he268_1977);
        reset = 1'b1;
        decode_enable = 1'b0;
        instruction = 32'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) drive(1'b0, 32'b0, "reset");

        // One strobe per type code
        t = t.first();
        do begin
            if (t != UNKNOWN) begin
                w = find_word(t);
                if (w == 32'b0) begin
                    $display("no encoding found for type code %0d", t);
                    abort_run();
                end
                drive(1'b1, w, t.name());
            end
            t = t.next();
        end while (t != t.first());
        d = ref_decode(32'hfff0_0093, bub);  // addi x1, x0, -1
        check("addi_neg ref imm", {64{1'b1}}, d.imm);
        drive(1'b1, 32'hfff0_0093, "addi_neg");

        for (int a = 32; a < 64; a++) begin
            shift_case("slli", OPC_OP_IMM, 3'b001, FUNCT7_BASE, a, SLLI);
            shift_case("srli", OPC_OP_IMM, 3'b101, FUNCT7_BASE, a, SRLI);
            shift_case("srai", OPC_OP_IMM, 3'b101, FUNCT7_ALT, a, SRAI);
        end
        repeat (10) begin
            shift_case("slliw", OPC_OP_IMM_32, 3'b001, FUNCT7_BASE, $urandom_range(0, 31), SLLIW);
            shift_case("srliw", OPC_OP_IMM_32, 3'b101, FUNCT7_BASE, $urandom_range(0, 31), SRLIW);
            shift_case("sraiw", OPC_OP_IMM_32, 3'b101, FUNCT7_ALT, $urandom_range(0, 31), SRAIW);
        end

        // M extension, unknown opcodes, bad shift funct7
        for (int f = 0; f < 8; f++) begin
            w = {7'b0000001, 10'($urandom), f[2:0], 5'($urandom), 7'b0};
            illegal_case("mext_op", w | OPC_OP);
            illegal_case("mext_op32", w | OPC_OP_32);
        end
        repeat (10) begin
            w = $urandom;
            while (known_opcode(w[6:0]))
                w[6:0] = $urandom;
            illegal_case("bad_opcode", w);
        end
        illegal_case("bad_slli", {6'b010000, 6'd5, 5'd1, 3'b001, 5'd2, OPC_OP_IMM});
        illegal_case("bad_srli", {6'b000001, 6'd9, 5'd3, 3'b101, 5'd4, OPC_OP_IMM});
        illegal_case("bad_slliw", {FUNCT7_ALT, 5'd7, 5'd5, 3'b001, 5'd6, OPC_OP_IMM_32});
        illegal_case("bad_sraiw", {7'b0000001, 5'd2, 5'd7, 3'b101, 5'd8, OPC_OP_IMM_32});

        for (int i = 0; i < STREAM_LEN; i++) begin
            case ($urandom_range(0, 3))
                0: drive(1'b0, $urandom, "idle");  // Ignored without a strobe
                1: drive(1'b1, 32'b0, "zero");
                2: drive(1'b1, random_word(), "stream");
                default: drive(1'b1, $urandom, "stream_raw");
            endcase
        end
        repeat (3) drive(1'b0, 32'b0, "drain");

        if (want_q.size() != 0) begin
            $display("%0d expected decode completions never arrived", want_q.size());
            abort_run();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // Outputs settle after the rising edge, sampled on the falling edge
    always @(negedge clk) begin
        decode_out_t want;
        string       name;
        if (reset) begin
            check("reset complete", 1'b0, decode_complete);
            check("reset decoded", '0, decoded);
        end else if (decode_complete) begin
            if (!strobe_seen) begin
                $display("decode_complete without a non-zero strobe one cycle earlier");
                abort_run();
            end
            if (want_q.size() == 0) begin
                $display("decode_complete arrived with no decode outstanding");
                abort_run();
            end
            want = want_q.pop_front();
            name = name_q.pop_front();
            check({name, " type"}, want.instr_type, decoded.instr_type);
            check({name, " regs"}, {want.opcode, want.rd, want.rs1, want.rs2},
                  {decoded.opcode, decoded.rd, decoded.rs1, decoded.rs2});
            check({name, " imm"}, want.imm, decoded.imm);
            check({name, " shamt"}, want.shamt, decoded.shamt);
            check({name, " flags"}, {want.memory_access, want.illegal},
                  {decoded.memory_access, decoded.illegal});
        end else begin
            check("hold decoded", last_decoded, decoded);
        end
        last_decoded = decoded;
        strobe_seen = decode_enable && (instruction != 32'b0);  // Captured at the next edge
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD + 200);
        $display("timeout: the test sequence did not finish in time");
        abort_run();
    end

endmodule

// File: rv_decode.f
+incdir+dv
design/rv_decode_pkg.sv
design/field_extract.sv
design/imm_gen.sv
design/instr_classify.sv
design/decode_stage.sv
design/rv_decoder_top.sv
dv/rv_decoder_tb.sv
